// ==== cekirdek_paket.sv ====
package cekirdek_paket;

   localparam int PS_BIT = 32;
   localparam int VERI_BIT = 32;

   // predictor table indexed by ps[7:2]
   localparam int ONGORU_IDX_BIT = 6;
   localparam int ONGORU_SATIR = 1 << ONGORU_IDX_BIT;

   // 2-bit saturating counters reset to weakly-not-taken
   localparam int SAYAC_BIT = 2;
   localparam logic [SAYAC_BIT-1:0] SAYAC_BASLANGIC = 2'b01;
   localparam logic [SAYAC_BIT-1:0] SAYAC_UST = 2'b11;
   localparam logic [SAYAC_BIT-1:0] SAYAC_ALT = 2'b00;

   // branch and jump micro-op codes
   typedef enum logic [3:0] {
      BEQ   = 4'd0,
      BNE   = 4'd1,
      BLT   = 4'd2,
      BGE   = 4'd3,
      BLTU  = 4'd4,
      BGEU  = 4'd5,
      JAL   = 4'd6,
      JALR  = 4'd7,
      CJAL  = 4'd8,
      CJALR = 4'd9
   } dal_kod_t;

   typedef struct packed {
      logic                gecerli;
      dal_kod_t            kod;
      logic [PS_BIT-1:0]   ps;
      logic [VERI_BIT-1:0] rs1;
      logic [VERI_BIT-1:0] rs2;
      logic [VERI_BIT-1:0] anlik;
      // direction predicted by fetch
      logic                atladi;
      logic                rvc;
   } dal_uop_t;

   typedef struct packed {
      logic esittir;
      logic kucuktur;
      logic kucuktur_isaretsiz;
   } amb_bayrak_t;

   // g1 fetch redirect
   typedef struct packed {
      logic              gecerli;
      logic [PS_BIT-1:0] ps;
   } yonlendirme_t;

   // g2 predictor training
   typedef struct packed {
      logic              gecerli;
      logic [PS_BIT-1:0] ps;
      logic [PS_BIT-1:0] hedef;
      logic              atladi;
      logic              hatali;
   } guncelleme_t;

endpackage

// ==== dallanma_amb.sv ====
module dallanma_amb (
   input  cekirdek_paket::dal_uop_t    uop_i,
   output cekirdek_paket::amb_bayrak_t bayrak_o,
   output logic [cekirdek_paket::VERI_BIT-1:0] toplayici_is0_o
);

   import cekirdek_paket::*;

   logic [VERI_BIT-1:0] is0;

   // three-way compare of rs1 against rs2
   always_comb begin
      bayrak_o.esittir = (uop_i.rs1 == uop_i.rs2);
      bayrak_o.kucuktur = ($signed(uop_i.rs1) < $signed(uop_i.rs2));
      bayrak_o.kucuktur_isaretsiz = (uop_i.rs1 < uop_i.rs2);
   end

   // register-indirect jumps add to rs1, everything else to pc
   always_comb begin
      case (uop_i.kod)
         JALR,
         CJALR: begin
            is0 = uop_i.rs1;
         end
         default: begin
            is0 = uop_i.ps;
         end
      endcase
   end

   assign toplayici_is0_o = is0;

endmodule

// ==== dallanma_birimi.sv ====
module dallanma_birimi (
   input  cekirdek_paket::dal_uop_t     uop_i,
   input  cekirdek_paket::amb_bayrak_t  bayrak_i,
   input  logic [cekirdek_paket::VERI_BIT-1:0] toplayici_is0_i,
   output cekirdek_paket::yonlendirme_t yonlendir_o,
   output cekirdek_paket::guncelleme_t  guncelle_o,
   output logic [cekirdek_paket::PS_BIT-1:0]   ps_atlamadi_o
);

   import cekirdek_paket::*;

   logic [VERI_BIT-1:0] toplayici_sonuc;
   logic [PS_BIT-1:0]   ps_atladi;
   logic [PS_BIT-1:0]   ps_atlamadi;
   logic [PS_BIT-1:0]   hedef_ps;

   // decoded op class
   logic kosullu;
   logic atlama;
   logic yazmac_hedef;
   logic kisa;

   logic atladi;
   logic hatali;

   // adder with its base from dallanma_amb
   assign toplayici_sonuc = toplayici_is0_i + uop_i.anlik;

   always_comb begin
      kosullu = 1'b0;
      atlama = 1'b0;
      yazmac_hedef = 1'b0;
      kisa = uop_i.rvc;
      atladi = 1'b0;

      case (uop_i.kod)
         BEQ: begin
            kosullu = 1'b1;
            atladi = bayrak_i.esittir;
         end
         BNE: begin
            kosullu = 1'b1;
            atladi = !bayrak_i.esittir;
         end
         BLT: begin
            kosullu = 1'b1;
            atladi = bayrak_i.kucuktur;
         end
         BGE: begin
            kosullu = 1'b1;
            atladi = !bayrak_i.kucuktur;
         end
         BLTU: begin
            kosullu = 1'b1;
            atladi = bayrak_i.kucuktur_isaretsiz;
         end
         BGEU: begin
            kosullu = 1'b1;
            atladi = !bayrak_i.kucuktur_isaretsiz;
         end
         JAL: begin
            atlama = 1'b1;
         end
         JALR: begin
            atlama = 1'b1;
            yazmac_hedef = 1'b1;
         end
         CJAL: begin
            atlama = 1'b1;
            kisa = 1'b1;
         end
         CJALR: begin
            atlama = 1'b1;
            yazmac_hedef = 1'b1;
            kisa = 1'b1;
         end
         default: begin
            // nothing asserted for an unknown code
            kosullu = 1'b0;
         end
      endcase
   end

   always_comb begin
      ps_atladi = toplayici_sonuc;
      // jalr targets drop bit 0
      if (yazmac_hedef) begin
         ps_atladi[0] = 1'b0;
      end

      if (kisa) begin
         ps_atlamadi = uop_i.ps + PS_BIT'(2);
      end else begin
         ps_atlamadi = uop_i.ps + PS_BIT'(4);
      end

      hedef_ps = (atladi || atlama) ? ps_atladi : ps_atlamadi;
      hatali = kosullu && (atladi != uop_i.atladi);
   end

   // g1 on jumps and on any misprediction
   always_comb begin
      yonlendir_o = '0;
      if (uop_i.gecerli && (atlama || hatali)) begin
         yonlendir_o.gecerli = 1'b1;
         yonlendir_o.ps = hedef_ps;
      end
   end

   // g2 only for conditional branches
   always_comb begin
      guncelle_o = '0;
      if (uop_i.gecerli && kosullu) begin
         guncelle_o.gecerli = 1'b1;
         guncelle_o.ps = uop_i.ps;
         guncelle_o.hedef = hedef_ps;
         guncelle_o.atladi = atladi;
         guncelle_o.hatali = hatali;
      end
   end

   // link address
   assign ps_atlamadi_o = ps_atlamadi;

endmodule

// ==== dallanma_denetleyici.sv ====
module dallanma_denetleyici (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   input  cekirdek_paket::dal_uop_t           uop_i,
   input  logic [cekirdek_paket::PS_BIT-1:0]  ongoru_ps_i,
   input  logic                               ongoru_atla_i,
   input  cekirdek_paket::yonlendirme_t       yonlendir_i,
   input  cekirdek_paket::guncelleme_t        guncelle_i,
   input  logic [cekirdek_paket::PS_BIT-1:0]  ps_atlamadi_i,
   input  logic                               tablo_gecerli_i,
   input  cekirdek_paket::yonlendirme_t       tablo_yon_i,
   output int                                 kontrol_o,
   output int                                 deger_hata_o,
   output int                                 tablo_hata_o
);

   import cekirdek_paket::*;

   // one-entry copy of the execute register
   dal_uop_t     model_q;
   logic         tablo_var_q;
   yonlendirme_t tablo_yon_q;
   logic [1:0]   sayac_q [64];

   yonlendirme_t exp_yon;
   guncelleme_t  exp_gun;
   logic         exp_atladi;

   function automatic logic kosullu_mu(dal_uop_t u);
      logic k;
      case (u.kod)
         BEQ, BNE, BLT, BGE, BLTU, BGEU: k = 1'b1;
         default: k = 1'b0;
      endcase
      return k;
   endfunction

   function automatic logic atlama_mu(dal_uop_t u);
      logic k;
      case (u.kod)
         JAL, JALR, CJAL, CJALR: k = 1'b1;
         default: k = 1'b0;
      endcase
      return k;
   endfunction

   // real direction of a conditional branch
   function automatic logic gercek_yon(dal_uop_t u);
      logic y;
      case (u.kod)
         BEQ:  y = (u.rs1 == u.rs2);
         BNE:  y = (u.rs1 != u.rs2);
         BLT:  y = ($signed(u.rs1) < $signed(u.rs2));
         BGE:  y = ($signed(u.rs1) >= $signed(u.rs2));
         BLTU: y = (u.rs1 < u.rs2);
         BGEU: y = (u.rs1 >= u.rs2);
         default: y = 1'b0;
      endcase
      return y;
   endfunction

   function automatic logic [31:0] atlanan_adres(dal_uop_t u);
      logic [31:0] a;
      if (u.kod == JALR || u.kod == CJALR) begin
         a = (u.rs1 + u.anlik) & 32'hffff_fffe;
      end else begin
         a = u.ps + u.anlik;
      end
      return a;
   endfunction

   function automatic logic [31:0] sonraki_adres(dal_uop_t u);
      logic kisa;
      kisa = u.rvc || u.kod == CJAL || u.kod == CJALR;
      return kisa ? u.ps + 32'd2 : u.ps + 32'd4;
   endfunction

   function automatic logic [1:0] doyur(logic [1:0] s, logic atladi);
      if (atladi) begin
         return (s == 2'd3) ? s : s + 2'd1;
      end
      return (s == 2'd0) ? s : s - 2'd1;
   endfunction

   task automatic karsilastir(input string ad, input logic [31:0] beklenen,
                              input logic [31:0] gelen, input bit tablodan);
      kontrol_o++;
      if (gelen !== beklenen) begin
         $display("ERROR %0t %s expected %h got %h", $time, ad, beklenen, gelen);
         if (tablodan) begin
            tablo_hata_o++;
         end else begin
            deger_hata_o++;
         end
      end
   endtask

   initial begin
      kontrol_o = 0;
      deger_hata_o = 0;
      tablo_hata_o = 0;
   end

   always_comb begin
      exp_atladi = gercek_yon(model_q);
      exp_gun.gecerli = model_q.gecerli && kosullu_mu(model_q);
      exp_gun.ps = model_q.ps;
      exp_gun.hedef = exp_atladi ? atlanan_adres(model_q) : sonraki_adres(model_q);
      exp_gun.atladi = exp_atladi;
      exp_gun.hatali = exp_atladi != model_q.atladi;
      exp_yon.gecerli = (model_q.gecerli && atlama_mu(model_q))
                        || (exp_gun.gecerli && exp_gun.hatali);
      if (atlama_mu(model_q) || exp_atladi) begin
         exp_yon.ps = atlanan_adres(model_q);
      end else begin
         exp_yon.ps = sonraki_adres(model_q);
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         model_q <= '0;
         tablo_var_q <= 1'b0;
         tablo_yon_q <= '0;
         for (int i = 0; i < 64; i++) begin
            sayac_q[i] <= 2'd1;
         end
      end else begin
         if (exp_gun.gecerli) begin
            sayac_q[exp_gun.ps[7:2]] <= doyur(sayac_q[exp_gun.ps[7:2]], exp_gun.atladi);
         end
         model_q <= uop_i;
         // younger op dies behind a redirect
         model_q.gecerli <= uop_i.gecerli && !exp_yon.gecerli;
         tablo_var_q <= tablo_gecerli_i;
         tablo_yon_q <= tablo_yon_i;
      end
   end

   always @(negedge clk_i) begin
      if (rst_n_i) begin
         karsilastir("yonlendir_o.gecerli", exp_yon.gecerli, yonlendir_i.gecerli, 1'b0);
         if (exp_yon.gecerli) begin
            karsilastir("yonlendir_o.ps", exp_yon.ps, yonlendir_i.ps, 1'b0);
         end
         karsilastir("guncelle_o.gecerli", exp_gun.gecerli, guncelle_i.gecerli, 1'b0);
         if (exp_gun.gecerli) begin
            karsilastir("guncelle_o.ps", exp_gun.ps, guncelle_i.ps, 1'b0);
            karsilastir("guncelle_o.hedef", exp_gun.hedef, guncelle_i.hedef, 1'b0);
            karsilastir("guncelle_o.atladi", exp_gun.atladi, guncelle_i.atladi, 1'b0);
            karsilastir("guncelle_o.hatali", exp_gun.hatali, guncelle_i.hatali, 1'b0);
         end
         if (model_q.gecerli && (kosullu_mu(model_q) || atlama_mu(model_q))) begin
            karsilastir("ps_atlamadi_o", sonraki_adres(model_q), ps_atlamadi_i, 1'b0);
         end
         karsilastir("ongoru_atla_o", sayac_q[ongoru_ps_i[7:2]][1], ongoru_atla_i, 1'b0);
         // hand-written row expectations
         if (tablo_var_q) begin
            karsilastir("yonlendir_o.gecerli", tablo_yon_q.gecerli, yonlendir_i.gecerli, 1'b1);
            if (tablo_yon_q.gecerli) begin
               karsilastir("yonlendir_o.ps", tablo_yon_q.ps, yonlendir_i.ps, 1'b1);
            end
         end
      end
   end

endmodule

// ==== dallanma_ongorucu.sv ====
module dallanma_ongorucu (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   input  logic [cekirdek_paket::PS_BIT-1:0]  ongoru_ps_i,
   output logic                               ongoru_atla_o,
   input  cekirdek_paket::guncelleme_t        guncelle_i
);

   import cekirdek_paket::*;

   logic [SAYAC_BIT-1:0] sayac_q [ONGORU_SATIR];

   logic [ONGORU_IDX_BIT-1:0] oku_idx;
   logic [ONGORU_IDX_BIT-1:0] yaz_idx;
   logic [SAYAC_BIT-1:0]      eski_sayac;
   logic [SAYAC_BIT-1:0]      yeni_sayac;

   // word-aligned index from bits 7 down to 2
   assign oku_idx = ongoru_ps_i[ONGORU_IDX_BIT+1:2];
   assign yaz_idx = guncelle_i.ps[ONGORU_IDX_BIT+1:2];

   // prediction is the counter msb
   assign ongoru_atla_o = sayac_q[oku_idx][SAYAC_BIT-1];

   assign eski_sayac = sayac_q[yaz_idx];

   // saturate at both ends
   always_comb begin
      yeni_sayac = eski_sayac;
      if (guncelle_i.atladi) begin
         if (eski_sayac != SAYAC_UST) begin
            yeni_sayac = eski_sayac + 1'b1;
         end
      end else begin
         if (eski_sayac != SAYAC_ALT) begin
            yeni_sayac = eski_sayac - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < ONGORU_SATIR; i++) begin
            sayac_q[i] <= SAYAC_BASLANGIC;
         end
      end else if (guncelle_i.gecerli) begin
         sayac_q[yaz_idx] <= yeni_sayac;
      end
   end

endmodule

// ==== dallanma_props.sv ====
module dallanma_props (
   input logic                         clk_i,
   input logic                         rst_n_i,
   input cekirdek_paket::dal_uop_t     yurutme_uop_i,
   input cekirdek_paket::yonlendirme_t yonlendir_i,
   input cekirdek_paket::guncelleme_t  guncelle_i
);

   import cekirdek_paket::*;

   // quiet right after reset release
   sifir_sonrasi: assert property (@(posedge clk_i)
      $rose(rst_n_i) |-> !yonlendir_i.gecerli && !guncelle_i.gecerli)
      else $error("output valid right after reset");

   gecersiz_uop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !yurutme_uop_i.gecerli |-> !yonlendir_i.gecerli && !guncelle_i.gecerli)
      else $error("output valid for an invalid micro-op");

   bilinmeyen_kod: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (yurutme_uop_i.kod > CJALR) |-> !yonlendir_i.gecerli && !guncelle_i.gecerli)
      else $error("output valid for an unknown opcode");

   hizali_hedef: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      yonlendir_i.gecerli |-> !yonlendir_i.ps[0])
      else $error("redirect target has bit 0 set");

   // a branch redirects exactly when mispredicted
   hatali_yonlendirme: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      guncelle_i.gecerli |-> (yonlendir_i.gecerli == guncelle_i.hatali))
      else $error("redirect disagrees with misprediction flag");

endmodule

// ==== dallanma_tb.sv ====
module dallanma_tb;

   import cekirdek_paket::*;

   localparam int SAAT_PERIYOT = 100;
   localparam int RESET_CEVRIM = 16;

   typedef struct packed {
      logic        gecerli;
      dal_kod_t    kod;
      logic [31:0] rs1;
      logic [31:0] rs2;
      logic [31:0] ps;
      logic [31:0] anlik;
      logic        tahmin;
      logic        rvc;
      logic        rastgele;
      logic        yon;
      logic [31:0] hedef;
   } satir_t;

   satir_t tablo[$];
   int     satir_sayisi;

   logic         clk_i;
   logic         rst_n_i;
   dal_uop_t     uop;
   logic [31:0]  ongoru_ps;
   logic         ongoru_atla;
   yonlendirme_t yonlendir;
   guncelleme_t  guncelle;
   logic [31:0]  ps_atlamadi;
   logic         tablo_gecerli;
   yonlendirme_t tablo_yon;
   int           kontrol;
   int           deger_hata;
   int           tablo_hata;

   dallanma_yurutme_ust dallanma_yurutme_ust_inst (
      .clk_i         ( clk_i ),
      .rst_n_i       ( rst_n_i ),
      .uop_i         ( uop ),
      .ongoru_ps_i   ( ongoru_ps ),
      .ongoru_atla_o ( ongoru_atla ),
      .yonlendir_o   ( yonlendir ),
      .guncelle_o    ( guncelle ),
      .ps_atlamadi_o ( ps_atlamadi )
   );

   dallanma_denetleyici dallanma_denetleyici_inst (
      .clk_i           ( clk_i ),
      .rst_n_i         ( rst_n_i ),
      .uop_i           ( uop ),
      .ongoru_ps_i     ( ongoru_ps ),
      .ongoru_atla_i   ( ongoru_atla ),
      .yonlendir_i     ( yonlendir ),
      .guncelle_i      ( guncelle ),
      .ps_atlamadi_i   ( ps_atlamadi ),
      .tablo_gecerli_i ( tablo_gecerli ),
      .tablo_yon_i     ( tablo_yon ),
      .kontrol_o       ( kontrol ),
      .deger_hata_o    ( deger_hata ),
      .tablo_hata_o    ( tablo_hata )
   );

   bind dallanma_yurutme_ust dallanma_props dallanma_props_inst (
      .clk_i         ( clk_i ),
      .rst_n_i       ( rst_n_i ),
      .yurutme_uop_i ( yurutme_uop ),
      .yonlendir_i   ( yonlendir_o ),
      .guncelle_i    ( guncelle_o )
   );

   initial begin
      clk_i = 1'b0;
   end

   always #(SAAT_PERIYOT / 2) clk_i = ~clk_i;

   task automatic satir_ekle(input logic g, input dal_kod_t k, input logic [31:0] a,
                             input logic [31:0] b, input logic [31:0] ps,
                             input logic [31:0] im, input logic tahmin, input logic rvc,
                             input logic rnd, input logic yon, input logic [31:0] hedef);
      tablo.push_back({g, k, a, b, ps, im, tahmin, rvc, rnd, yon, hedef});
   endtask

   // valid, code, rs1, rs2, ps, imm, predicted, rvc, random, redirect, target
   task automatic tablo_doldur();
      satir_ekle(1, BEQ,   32'd5, 32'd5, 32'h100, 32'h20, 1, 0, 0, 0, 32'h0);
      satir_ekle(1, BEQ,   32'd5, 32'd6, 32'h104, 32'h20, 0, 0, 0, 0, 32'h0);
      // unknown code reaching execute
      satir_ekle(1, dal_kod_t'(4'hf), 32'd1, 32'd1, 32'h220, 32'h8, 0, 0, 0, 0, 32'h0);
      satir_ekle(1, BNE,   32'd7, 32'd7, 32'h108, 32'h40, 1, 0, 0, 1, 32'h10c);
      // killed behind the redirect above
      satir_ekle(1, BNE,   32'd1, 32'd2, 32'h10c, 32'h10, 0, 0, 0, 0, 32'h0);
      satir_ekle(1, BLT,   32'hffff_fff0, 32'd3, 32'h200, 32'h80, 0, 0, 0, 1, 32'h280);
      satir_ekle(1, JAL,   32'd0, 32'd0, 32'h300, 32'h100, 0, 0, 0, 0, 32'h0);
      satir_ekle(1, BLTU,  32'hffff_fff0, 32'd3, 32'h204, 32'h40, 0, 0, 0, 0, 32'h0);
      satir_ekle(1, BGE,   32'hffff_fff0, 32'd3, 32'h208, 32'h40, 0, 0, 0, 0, 32'h0);
      satir_ekle(1, BGEU,  32'hffff_fff0, 32'd3, 32'h20c, 32'h40, 1, 0, 0, 0, 32'h0);
      satir_ekle(1, BGE,   32'd3, 32'd3, 32'h210, 32'h30, 0, 1, 0, 1, 32'h240);
      satir_ekle(1, BEQ,   32'd0, 32'd0, 32'h214, 32'h4, 0, 0, 0, 0, 32'h0);
      satir_ekle(1, BLTU,  32'd3, 32'hffff_fff0, 32'h218, 32'h20, 1, 0, 0, 0, 32'h0);
      satir_ekle(1, BLT,   32'd3, 32'hffff_fff0, 32'h21c, 32'h20, 1, 1, 0, 1, 32'h21e);
      satir_ekle(1, dal_kod_t'(4'hf), 32'd1, 32'd1, 32'h220, 32'h8, 0, 0, 0, 0, 32'h0);
      satir_ekle(1, JAL,   32'd0, 32'd0, 32'h400, 32'h1000, 0, 0, 0, 1, 32'h1400);
      satir_ekle(0, BEQ,   32'd2, 32'd2, 32'h404, 32'h8, 0, 0, 0, 0, 32'h0);
      satir_ekle(1, JALR,  32'h2001, 32'd0, 32'h500, 32'h10, 0, 0, 0, 1, 32'h2010);
      satir_ekle(1, CJAL,  32'd0, 32'd0, 32'h600, 32'h20, 0, 1, 0, 0, 32'h0);
      satir_ekle(1, CJAL,  32'd0, 32'd0, 32'h600, 32'hffff_ff00, 0, 1, 0, 1, 32'h500);
      satir_ekle(0, JAL,   32'd0, 32'd0, 32'h604, 32'h40, 0, 0, 0, 0, 32'h0);
      satir_ekle(1, CJALR, 32'h3003, 32'd0, 32'h700, 32'h4, 0, 0, 0, 1, 32'h3006);
      satir_ekle(1, BEQ,   32'd9, 32'd9, 32'h100, 32'h20, 1, 0, 0, 0, 32'h0);
      // repeated training of counter 0
      satir_ekle(1, BEQ,   32'd9, 32'd9, 32'h100, 32'h20, 1, 0, 0, 0, 32'h0);
      satir_ekle(1, BEQ,   32'd9, 32'd9, 32'h100, 32'h20, 1, 0, 0, 0, 32'h0);
      satir_ekle(1, BNE,   32'd9, 32'd9, 32'h100, 32'h20, 1, 0, 0, 1, 32'h104);
      satir_ekle(1, BNE,   32'd9, 32'd9, 32'h100, 32'h20, 0, 0, 0, 0, 32'h0);
      satir_ekle(1, BNE,   32'd9, 32'd9, 32'h100, 32'h20, 0, 0, 0, 0, 32'h0);
      // random operands checked by the model only
      satir_ekle(1, BLT,   32'd0, 32'd0, 32'h0c0, 32'h60, 1, 0, 1, 0, 32'h0);
      satir_ekle(1, BGEU,  32'd0, 32'd0, 32'h0c4, 32'h60, 0, 0, 1, 0, 32'h0);
      satir_ekle(1, BNE,   32'd0, 32'd0, 32'h0c8, 32'h60, 1, 1, 1, 0, 32'h0);
      satir_ekle(1, JALR,  32'd0, 32'd0, 32'h0cc, 32'h60, 0, 0, 1, 0, 32'h0);
   endtask

   initial begin
      dal_uop_t siradaki;
      satir_t   s;

      void'($urandom(32'ha3a5_22f8));
      rst_n_i = 1'b0;
      uop = '0;
      ongoru_ps = '0;
      tablo_gecerli = 1'b0;
      tablo_yon = '0;
      tablo_doldur();
      satir_sayisi = tablo.size();

      repeat (RESET_CEVRIM) @(posedge clk_i);
      rst_n_i <= 1'b1;

      foreach (tablo[i]) begin
         @(posedge clk_i);
         s = tablo[i];
         siradaki = {s.gecerli, s.kod, s.ps, s.rs1, s.rs2, s.anlik, s.tahmin, s.rvc};
         if (s.rastgele) begin
            siradaki.rs1 = $urandom();
            siradaki.rs2 = ($urandom() % 2 == 0) ? siradaki.rs1 : $urandom();
         end
         uop <= siradaki;
         ongoru_ps <= s.ps;
         tablo_gecerli <= !s.rastgele;
         tablo_yon <= {s.yon, s.hedef};
      end

      @(posedge clk_i);
      uop <= '0;
      tablo_gecerli <= 1'b0;
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);

      $display("checks %0d, model errors %0d, table errors %0d",
               kontrol, deger_hata, tablo_hata);
      if (deger_hata == 0 && tablo_hata == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

   // watchdog
   initial begin
      wait (satir_sayisi != 0);
      #((satir_sayisi + 40) * SAAT_PERIYOT);
      $display("simulation timed out before the stimulus table completed");
      $display("Finished with errors");
      $finish;
   end

endmodule

// ==== dallanma_yurutme_ust.sv ====
module dallanma_yurutme_ust (
   input  logic                               clk_i,
   input  logic                               rst_n_i,
   input  cekirdek_paket::dal_uop_t           uop_i,
   input  logic [cekirdek_paket::PS_BIT-1:0]  ongoru_ps_i,
   output logic                               ongoru_atla_o,
   output cekirdek_paket::yonlendirme_t       yonlendir_o,
   output cekirdek_paket::guncelleme_t        guncelle_o,
   output logic [cekirdek_paket::PS_BIT-1:0]  ps_atlamadi_o
);

   import cekirdek_paket::*;

   dal_uop_t            yurutme_uop;
   amb_bayrak_t         bayrak;
   logic [VERI_BIT-1:0] toplayici_is0;

   yurutme_boru_yazmaci yurutme_boru_yazmaci_inst (
      .clk_i       ( clk_i ),
      .rst_n_i     ( rst_n_i ),
      .uop_i       ( uop_i ),
      .yonlendir_i ( yonlendir_o ),
      .uop_o       ( yurutme_uop )
   );

   dallanma_amb dallanma_amb_inst (
      .uop_i           ( yurutme_uop ),
      .bayrak_o        ( bayrak ),
      .toplayici_is0_o ( toplayici_is0 )
   );

   dallanma_birimi dallanma_birimi_inst (
      .uop_i           ( yurutme_uop ),
      .bayrak_i        ( bayrak ),
      .toplayici_is0_i ( toplayici_is0 ),
      .yonlendir_o     ( yonlendir_o ),
      .guncelle_o      ( guncelle_o ),
      .ps_atlamadi_o   ( ps_atlamadi_o )
   );

   dallanma_ongorucu dallanma_ongorucu_inst (
      .clk_i         ( clk_i ),
      .rst_n_i       ( rst_n_i ),
      .ongoru_ps_i   ( ongoru_ps_i ),
      .ongoru_atla_o ( ongoru_atla_o ),
      .guncelle_i    ( guncelle_o )
   );

endmodule

// ==== verilog.f ====
cekirdek_paket.sv
yurutme_boru_yazmaci.sv
dallanma_amb.sv
dallanma_birimi.sv
dallanma_ongorucu.sv
dallanma_yurutme_ust.sv
dallanma_props.sv
dallanma_denetleyici.sv
dallanma_tb.sv

// ==== yurutme_boru_yazmaci.sv ====
module yurutme_boru_yazmaci (
   input  logic                      clk_i,
   input  logic                      rst_n_i,
   input  cekirdek_paket::dal_uop_t     uop_i,
   input  cekirdek_paket::yonlendirme_t yonlendir_i,
   output cekirdek_paket::dal_uop_t     uop_o
);

   import cekirdek_paket::*;

   dal_uop_t uop_q;
   logic     gecerli_q;

   // a redirect from the held op kills the next one, which is wrong-path
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         gecerli_q <= 1'b0;
      end else begin
         gecerli_q <= uop_i.gecerli && !yonlendir_i.gecerli;
      end
   end

   // payload
   always_ff @(posedge clk_i) begin
      uop_q <= uop_i;
   end

   always_comb begin
      uop_o = uop_q;
      uop_o.gecerli = gecerli_q;
   end

endmodule
